//--- logic/ifu_pkg.sv
// fetch constants, counter widths, fetch enums and packed structs for the memory and decode links
package ifu_pkg;

   //********************
   // fetch constants
   localparam int unsigned     PC_W        = 32;              // byte pc width
   localparam logic [PC_W-1:0] RESET_PC    = 32'h0000_0100;   // first fetch after reset
   localparam int unsigned     FB_DEPTH    = 4;               // fetch buffer entries
   localparam int unsigned     MEM_CREDITS = 2;               // memory request slots
   localparam int unsigned     DEC_CREDITS = 4;               // decode buffer entries

   localparam int unsigned     FB_PTR_W    = $clog2(FB_DEPTH);        // fifo pointer
   localparam int unsigned     FB_CNT_W    = $clog2(FB_DEPTH + 1);    // 0..FB_DEPTH
   localparam int unsigned     MEM_CRED_W  = $clog2(MEM_CREDITS + 1); // 0..MEM_CREDITS
   localparam int unsigned     DEC_CRED_W  = $clog2(DEC_CREDITS + 1); // 0..DEC_CREDITS

   //********************
   // enums
   typedef enum logic {
      compressed,                    // 16 bit encoding
      full                           // 32 bit encoding, low bits 2'b11
   } instr_kind_e;

   typedef enum logic {
      idle,                          // nothing held
      have_low                       // low half of a straddling instr held
   } aln_state_e;

   //********************
   // link structs
   typedef struct packed {
      logic            valid;
      logic [PC_W-1:0] addr;         // byte address, word aligned
      logic            epoch;        // echoed back in the response
   } fetch_req_t;

   typedef struct packed {
      logic            valid;
      logic [31:0]     data;         // instruction memory word
      logic            epoch;        // epoch of the matching request
   } fetch_rsp_t;

   typedef struct packed {
      logic            valid;
      logic [PC_W-1:0] pc;           // redirect target, bit 0 zero
   } flush_t;

   typedef struct packed {
      logic [31:0]     word;
      logic [PC_W-1:0] pc;           // pc of the word, low two bits zero
   } fb_entry_t;

   typedef struct packed {
      logic            valid;
      logic [PC_W-1:0] pc;
      logic [31:0]     inst;         // upper half zero for compressed
      instr_kind_e     kind;
   } instr_pkt_t;

endpackage

//--- logic/fetch_ctl.sv
// fetch control with pc generation, flush redirect, memory credits, epoch and buffer reservations
`timescale 1ns/1ps

module fetch_ctl
   import ifu_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  flush_t     flush,          // redirect from execute
   input  logic       mem_credit,     // memory freed one request slot
   input  logic       slot_release,   // fetch buffer freed one reserved slot
   output fetch_req_t mem_req,        // word request to memory
   output logic       epoch           // current fetch epoch
);

   logic [PC_W-1:0]       pc_q;           // byte address of next word to fetch
   logic [MEM_CRED_W-1:0] mem_cred_q;     // free memory request slots
   logic [FB_CNT_W-1:0]   resv_q;         // fetch buffer slots reserved
   logic                  epoch_q;
   logic                  epoch_used_q;   // request sent in the current epoch
   logic                  drain_q;        // old path requests may still be out
   logic                  mem_idle;       // every memory credit is home
   logic                  space_ok;       // a buffer slot is free to reserve
   logic                  req_fire;

   //********************
   // request issue
   assign mem_idle = (mem_cred_q == MEM_CRED_W'(MEM_CREDITS));
   assign space_ok = (resv_q < FB_CNT_W'(FB_DEPTH));

   // after a flush, wait until every old request has returned so that a one bit
   // epoch can never alias an older path
   assign req_fire = rst_n &                     // quiet while reset is held
                     ~flush.valid &
                     (mem_cred_q != '0) &
                     space_ok &
                     (~drain_q | mem_idle);

   always_comb begin
      mem_req.valid = req_fire;
      mem_req.addr  = pc_q;            // always word aligned
      mem_req.epoch = epoch_q;         // tag for stale detection in fetch_buf
   end

   assign epoch = epoch_q;

   //********************
   // counters, pc and epoch
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pc_q         <= {RESET_PC[PC_W-1:2], 2'b00};
         mem_cred_q   <= MEM_CRED_W'(MEM_CREDITS);  // memory starts with all slots
         resv_q       <= '0;
         epoch_q      <= 1'b0;
         epoch_used_q <= 1'b0;
         drain_q      <= 1'b0;
      end else begin
         mem_cred_q <= mem_cred_q + MEM_CRED_W'(mem_credit) - MEM_CRED_W'(req_fire);
         resv_q     <= resv_q + FB_CNT_W'(req_fire) - FB_CNT_W'(slot_release); // not cleared on flush
         if (flush.valid) begin
            pc_q         <= {flush.pc[PC_W-1:2], 2'b00};  // word holding the target
            epoch_q      <= epoch_q ^ epoch_used_q;       // no new epoch if nothing was sent
            epoch_used_q <= 1'b0;
            drain_q      <= 1'b1;
         end else begin
            if (req_fire) begin
               pc_q         <= pc_q + PC_W'(4);          // next word
               epoch_used_q <= 1'b1;
            end
            if (mem_idle) begin
               drain_q <= 1'b0;                           // old path fully returned
            end
         end
      end
   end

   //********************
   // checks
   a_mem_cred_max : assert property (
      @(posedge clk) disable iff (!rst_n)
      mem_cred_q <= MEM_CRED_W'(MEM_CREDITS))
      else $error("memory credit count above MEM_CREDITS");

   a_resv_max : assert property (
      @(posedge clk) disable iff (!rst_n)
      resv_q <= FB_CNT_W'(FB_DEPTH))
      else $error("fetch buffer reservations above FB_DEPTH");

endmodule

//--- logic/fetch_buf.sv
// fetch buffer fifo with stale response drop, flush emptying and slot release reporting
`timescale 1ns/1ps

module fetch_buf
   import ifu_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  fetch_rsp_t mem_rsp,        // memory response, always accepted
   input  logic       epoch,          // current epoch from fetch_ctl
   input  flush_t     flush,          // empty and reload the response pc
   input  logic       pop,            // aligner is done with the head
   output fb_entry_t  head,
   output logic       head_valid,
   output logic       slot_release    // one reserved slot freed
);

   fb_entry_t           mem_q [FB_DEPTH];  // payload, no reset
   logic [FB_PTR_W-1:0] wr_ptr_q;
   logic [FB_PTR_W-1:0] rd_ptr_q;
   logic [FB_CNT_W-1:0] count_q;
   logic [FB_CNT_W-1:0] rel_pend_q;        // freed slots not yet reported
   logic [FB_CNT_W-1:0] freed;             // slots freed by pop or flush
   logic [PC_W-1:0]     rsp_pc_q;          // word pc of the next good response
   logic                stale;
   logic                push;
   logic                pop_ok;

   assign stale  = mem_rsp.valid & (flush.valid | (mem_rsp.epoch != epoch)); // old path data
   assign push   = mem_rsp.valid & ~stale;
   assign pop_ok = pop & head_valid & ~flush.valid;
   assign freed  = flush.valid ? count_q : FB_CNT_W'(pop_ok);

   assign head_valid   = (count_q != '0);
   assign head         = mem_q[rd_ptr_q];
   assign slot_release = (rel_pend_q != '0); // one per cycle

   always_ff @(posedge clk) begin
      if (push) begin
         mem_q[wr_ptr_q].word <= mem_rsp.data;
         mem_q[wr_ptr_q].pc   <= rsp_pc_q;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr_q   <= '0;
         rd_ptr_q   <= '0;
         count_q    <= '0;
         rel_pend_q <= '0;
         rsp_pc_q   <= {RESET_PC[PC_W-1:2], 2'b00};
      end else begin
         rel_pend_q <= rel_pend_q + freed + FB_CNT_W'(stale) - FB_CNT_W'(slot_release);
         if (flush.valid) begin
            rd_ptr_q <= wr_ptr_q;                       // empty
            count_q  <= '0;
            rsp_pc_q <= {flush.pc[PC_W-1:2], 2'b00};
         end else begin
            if (push) begin
               wr_ptr_q <= wr_ptr_q + FB_PTR_W'(1);     // wraps, depth is a power of two
               rsp_pc_q <= rsp_pc_q + PC_W'(4);
            end
            if (pop_ok) begin
               rd_ptr_q <= rd_ptr_q + FB_PTR_W'(1);
            end
            count_q <= count_q + FB_CNT_W'(push) - FB_CNT_W'(pop_ok);
         end
      end
   end

   //********************
   // reservation in fetch_ctl keeps this from firing
   a_no_overflow : assert property (
      @(posedge clk) disable iff (!rst_n)
      push |-> (count_q < FB_CNT_W'(FB_DEPTH)))
      else $error("push into full fetch buffer");

endmodule

//--- logic/ifu_aligner.sv
// instruction aligner with parcel select, length decode, straddle assembly and decode credits
`timescale 1ns/1ps

module ifu_aligner
   import ifu_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  fb_entry_t  head,           // oldest fetch word
   input  logic       head_valid,
   input  flush_t     flush,          // restart at target parcel
   input  logic       dec_credit,     // decode freed one entry
   output logic       pop,            // head word fully used
   output instr_pkt_t instr           // one instruction per cycle at most
);

   aln_state_e            state_q;
   aln_state_e            state_d;
   logic                  upper_q;       // next parcel is the upper half of head
   logic                  upper_d;
   logic [15:0]           low_q;         // low half of a straddling full instr
   logic [PC_W-1:0]       low_pc_q;      // pc of that instruction
   logic [DEC_CRED_W-1:0] dec_cred_q;    // free decode entries
   logic                  go;            // data present and decode has room
   logic [15:0]           parcel;
   logic                  parcel_full;
   logic                  hold_low;      // stash the upper parcel this cycle

   //********************
   // parcel select and length
   assign go          = head_valid & (dec_cred_q != '0) & ~flush.valid;
   assign parcel      = upper_q ? head.word[31:16] : head.word[15:0];
   assign parcel_full = (parcel[1:0] == 2'b11);  // 32 bit encoding

   always_comb begin
      instr      = '0;
      instr.kind = compressed;
      pop        = 1'b0;
      upper_d    = upper_q;
      state_d    = state_q;
      hold_low   = 1'b0;
      if (go) begin
         case (state_q)
            have_low: begin
               // high half sits in the low parcel of the new head word
               instr.valid = 1'b1;
               instr.pc    = low_pc_q;
               instr.inst  = {head.word[15:0], low_q};
               instr.kind  = full;
               upper_d     = 1'b1;                       // upper parcel of this word next
               state_d     = idle;
            end
            default: begin
               if (upper_q && parcel_full) begin
                  hold_low = 1'b1;                       // straddles into next word
                  pop      = 1'b1;
                  upper_d  = 1'b0;
                  state_d  = have_low;
               end else if (upper_q) begin
                  instr.valid = 1'b1;                    // compressed in upper half
                  instr.pc    = head.pc + PC_W'(2);
                  instr.inst  = {16'h0000, parcel};
                  pop         = 1'b1;
                  upper_d     = 1'b0;
               end else if (parcel_full) begin
                  instr.valid = 1'b1;                    // whole word is one instr
                  instr.pc    = head.pc;
                  instr.inst  = head.word;
                  instr.kind  = full;
                  pop         = 1'b1;
               end else begin
                  instr.valid = 1'b1;                    // compressed in lower half
                  instr.pc    = head.pc;
                  instr.inst  = {16'h0000, parcel};
                  upper_d     = 1'b1;
               end
            end
         endcase
      end
   end

   //********************
   // state, held half and credits
   always_ff @(posedge clk) begin
      if (hold_low) begin
         low_q    <= parcel;
         low_pc_q <= head.pc + PC_W'(2);
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q    <= idle;
         upper_q    <= RESET_PC[1];
         dec_cred_q <= DEC_CRED_W'(DEC_CREDITS);    // decode buffer empty
      end else begin
         dec_cred_q <= dec_cred_q + DEC_CRED_W'(dec_credit) - DEC_CRED_W'(instr.valid);
         if (flush.valid) begin
            state_q <= idle;                        // drop any held half
            upper_q <= flush.pc[1];                 // target may start mid word
         end else begin
            state_q <= state_d;
            upper_q <= upper_d;
         end
      end
   end

   a_dec_cred_max : assert property (
      @(posedge clk) disable iff (!rst_n)
      dec_cred_q <= DEC_CRED_W'(DEC_CREDITS))
      else $error("decode credit count above DEC_CREDITS");

endmodule

//--- logic/ifu_top.sv
// instruction fetch unit top connecting fetch control, fetch buffer and aligner
`timescale 1ns/1ps

module ifu_top
   import ifu_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  flush_t     flush,          // redirect from execute
   input  fetch_rsp_t mem_rsp,        // in order responses
   input  logic       mem_credit,     // memory slot returned
   input  logic       dec_credit,     // decode entry returned
   output fetch_req_t mem_req,
   output instr_pkt_t instr
);

   logic      epoch;                  // ctl to buf
   logic      slot_release;           // buf to ctl
   fb_entry_t head;                   // buf to aligner
   logic      head_valid;
   logic      pop;                    // aligner to buf

   fetch_ctl fetch_ctl_inst (
      .clk          (clk),
      .rst_n        (rst_n),
      .flush        (flush),
      .mem_credit   (mem_credit),
      .slot_release (slot_release),
      .mem_req      (mem_req),
      .epoch        (epoch)
   );

   fetch_buf fetch_buf_inst (
      .clk          (clk),
      .rst_n        (rst_n),
      .mem_rsp      (mem_rsp),
      .epoch        (epoch),
      .flush        (flush),
      .pop          (pop),
      .head         (head),
      .head_valid   (head_valid),
      .slot_release (slot_release)
   );

   ifu_aligner ifu_aligner_inst (
      .clk          (clk),
      .rst_n        (rst_n),
      .head         (head),
      .head_valid   (head_valid),
      .flush        (flush),
      .dec_credit   (dec_credit),
      .pop          (pop),
      .instr        (instr)
   );

endmodule

//--- dv/ifu_checker.sv
// stream checker with reference instruction walk, request address and credit bound checks
`timescale 1ns/1ps

module ifu_checker
   import ifu_pkg::*;
#(
   parameter int IDX_W = 10                    // image index width
)(
   input  logic        clk,
   input  logic        rst_n,
   input  flush_t      flush,
   input  fetch_req_t  mem_req,
   input  logic        mem_credit,
   input  instr_pkt_t  instr,
   input  logic        dec_credit,
   input  logic [15:0] image_h [1 << IDX_W],
   output int          checked,
   output int          errors
);

   logic [PC_W-1:0] exp_pc   = RESET_PC;     // next pc on the expected path
   logic [PC_W-1:0] exp_addr = {RESET_PC[PC_W-1:2], 2'b00}; // next word request
   int              out_req  = 0;            // requests memory has not credited
   int              out_dec  = 0;            // instructions decode has not credited
   int              n_chk    = 0;
   int              n_err    = 0;

   assign checked = n_chk;
   assign errors  = n_err;

   function automatic logic [15:0] half_at(input logic [PC_W-1:0] a);
      return image_h[IDX_W'(a >> 1)];
   endfunction

   // expected instruction at pc, length from the low two bits
   function automatic instr_pkt_t ref_instr(input logic [PC_W-1:0] pc);
      instr_pkt_t  p;
      logic [15:0] lo;
      lo      = half_at(pc);
      p       = '0;
      p.valid = 1'b1;
      p.pc    = pc;
      if (lo[1:0] == 2'b11) begin
         p.inst = {half_at(pc + 32'd2), lo};  // high half may be in the next word
         p.kind = full;
      end else begin
         p.inst = {16'h0000, lo};
         p.kind = compressed;
      end
      return p;
   endfunction

   task automatic report_error(input string what);
      n_err++;
      $display("error at %0d ns: %s", $time, what);
   endtask

   task automatic compare_field(input string name, input logic [31:0] exp_v,
                                input logic [31:0] act_v);
      if (exp_v !== act_v) begin
         n_err++;
         $display("mismatch at %0d ns: %s expected %h, got %h", $time, name, exp_v, act_v);
      end
   endtask

   //********************
   // compare on every rising edge
   always @(posedge clk) begin
      instr_pkt_t want;
      want = ref_instr(exp_pc);
      if (!rst_n) begin
         if (mem_req.valid || instr.valid) begin
            report_error("request or instruction valid while reset is held");
         end
         exp_pc   = RESET_PC;
         exp_addr = {RESET_PC[PC_W-1:2], 2'b00};
         out_req  = 0;
         out_dec  = 0;
      end else begin
         out_req = out_req + int'(mem_req.valid) - int'(mem_credit);
         out_dec = out_dec + int'(instr.valid) - int'(dec_credit);
         if (out_req > MEM_CREDITS) begin
            report_error("more memory requests outstanding than MEM_CREDITS");
         end
         if (out_dec > DEC_CREDITS) begin
            report_error("more instructions uncredited than DEC_CREDITS");
         end
         if (mem_req.valid) begin
            compare_field("mem_req.addr", exp_addr, mem_req.addr);
         end
         if (flush.valid) begin
            exp_addr = {flush.pc[PC_W-1:2], 2'b00};  // word holding the target
         end else if (mem_req.valid) begin
            exp_addr = exp_addr + 32'd4;
         end
         if (flush.valid) begin
            if (instr.valid) begin
               report_error("instruction sent in the flush cycle");
            end
            exp_pc = flush.pc;                 // new path starts at the target
         end else if (instr.valid) begin
            compare_field("instr.pc", want.pc, instr.pc);
            compare_field("instr.inst", want.inst, instr.inst);
            compare_field("instr.kind", 32'(want.kind), 32'(instr.kind));
            n_chk++;
            exp_pc = exp_pc + ((want.kind == full) ? 32'd4 : 32'd2);
         end
      end
   end

endmodule

//--- dv/tb_ifu.sv
// testbench top with clock, reset, program image, memory and decode models, flushes and timeout
`timescale 1ns/1ps

module tb_ifu
   import ifu_pkg::*;
();

   localparam int IDX_W = 10;                  // image index width
   localparam int IMG_H = 1 << IDX_W;          // halfwords in the image
   localparam int N_EXP = 200;                 // instructions the sequence waits for
   localparam int LIMIT = 20 * N_EXP + 10;     // plus the reset cycles

   typedef struct packed {
      logic [PC_W-1:0] addr;
      logic            epoch;
      int              due;                    // cycle the response may go out
   } mem_op_t;

   logic        clk        = 1'b0;
   logic        rst_n;
   flush_t      flush;
   fetch_rsp_t  mem_rsp    = '0;
   logic        mem_credit = 1'b0;
   logic        dec_credit = 1'b0;
   fetch_req_t  mem_req;
   instr_pkt_t  instr;
   logic [15:0] image_h [IMG_H];               // program as halfwords
   int          seed  = 57844;
   int          cyc   = 0;
   int          owed  = 0;                     // decode credits not yet returned
   bit          fast  = 1'b1;                  // one cycle memory, free decode
   bit          stall = 1'b0;                  // decode withholds credits
   int          checked;
   int          errors;
   mem_op_t     req_q [$];                     // requests waiting for a response
   int          cred_q [$];                    // cycles when memory credits go back

   ifu_top ifu_top_inst (
      .clk        (clk),
      .rst_n      (rst_n),
      .flush      (flush),
      .mem_rsp    (mem_rsp),
      .mem_credit (mem_credit),
      .dec_credit (dec_credit),
      .mem_req    (mem_req),
      .instr      (instr)
   );

   ifu_checker #(.IDX_W(IDX_W)) ifu_checker_inst (
      .clk        (clk),
      .rst_n      (rst_n),
      .flush      (flush),
      .mem_req    (mem_req),
      .mem_credit (mem_credit),
      .instr      (instr),
      .dec_credit (dec_credit),
      .image_h    (image_h),
      .checked    (checked),
      .errors     (errors)
   );

   function automatic logic [31:0] word_at(input logic [PC_W-1:0] a);
      logic [IDX_W-1:0] i;
      i = IDX_W'(a >> 1);                      // wraps inside the image
      return {image_h[i + IDX_W'(1)], image_h[i]};
   endfunction

   function automatic logic [PC_W-1:0] pick_target();
      logic [IDX_W-1:0] h;
      h = IDX_W'($random(seed));
      return PC_W'(h) << 1;                    // halfword aligned
   endfunction

   task automatic send_flush(input logic [PC_W-1:0] target);
      @(negedge clk);
      flush.valid = 1'b1;
      flush.pc    = target;
      @(negedge clk);
      flush = '0;                              // one cycle wide
   endtask

   initial begin
      forever #10 clk = ~clk;
   end

   //********************
   // main sequence
   initial begin
      rst_n = 1'b0;
      flush = '0;
      for (int i = 0; i < IMG_H; i++) begin
         image_h[IDX_W'(i)] = 16'($random(seed));
         if (($random(seed) & 7) < 3) begin
            image_h[IDX_W'(i)][1:0] = 2'b11;   // more full encodings
         end
      end
      repeat (10) @(negedge clk);
      rst_n = 1'b1;
      wait (checked >= 40);                    // in order from RESET_PC, free links
      fast <= 1'b0;
      wait (checked >= 120);                   // random latency and credits
      send_flush(pick_target() & ~32'h3);      // word aligned target
      wait (checked >= 140);
      send_flush(pick_target() | 32'h2);       // upper parcel target
      wait (checked >= 160);
      repeat (3) send_flush(pick_target());    // redirects a cycle apart
      wait (checked >= 180);
      stall <= 1'b1;
      repeat (15) @(negedge clk);              // buffer fills, requests stop
      send_flush(pick_target());
      repeat (5) @(negedge clk);
      stall <= 1'b0;
      wait (checked >= N_EXP);
      repeat (5) @(negedge clk);
      $display("errors: %0d, instructions checked: %0d", errors, checked);
      if (errors == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

   //********************
   // memory and decode models, sample on rise, drive on fall
   always @(posedge clk) begin
      mem_op_t op;
      if (rst_n && mem_req.valid) begin
         op.addr  = mem_req.addr;
         op.epoch = mem_req.epoch;
         op.due   = cyc + (fast ? 1 : 1 + ($random(seed) & 3));   // 1 to 4 cycles
         req_q.push_back(op);
      end
      if (rst_n && instr.valid) begin
         owed++;
      end
      @(negedge clk);
      mem_rsp    = '0;
      mem_credit = 1'b0;
      dec_credit = 1'b0;
      if (req_q.size() > 0 && req_q[0].due <= cyc) begin
         op = req_q.pop_front();               // in request order
         mem_rsp.valid = 1'b1;
         mem_rsp.data  = word_at(op.addr);
         mem_rsp.epoch = op.epoch;
         cred_q.push_back(cyc + (fast ? 0 : int'($unsigned($random(seed)) % 3)));
      end
      if (cred_q.size() > 0 && cred_q[0] <= cyc) begin
         void'(cred_q.pop_front());
         mem_credit = 1'b1;
      end
      if (owed > 0 && !stall && (fast || ($random(seed) & 1) == 1)) begin
         owed--;
         dec_credit = 1'b1;                    // decode freed an entry
      end
   end

   always @(posedge clk) begin
      cyc <= cyc + 1;
      if (cyc >= LIMIT) begin
         $display("timeout: fetch hung, %0d of %0d instructions seen", checked, N_EXP);
         $display("errors: %0d, instructions checked: %0d", errors, checked);
         $display("Something failed");
         $finish;
      end
   end

endmodule

//--- build.f
logic/ifu_pkg.sv
logic/fetch_ctl.sv
logic/fetch_buf.sv
logic/ifu_aligner.sv
logic/ifu_top.sv
dv/ifu_checker.sv
dv/tb_ifu.sv

//--- Makefile
# Verilator flow for the instruction fetch unit testbench
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module tb_ifu -f build.f -o tb_ifu

run: compile
	./obj_dir/tb_ifu > $(LOG) 2>&1 || echo "Something failed" >> $(LOG)
	cat $(LOG)
	@if grep -q "Something failed" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
